// File: list.f
+incdir+src
src/int_div_pkg.sv
src/div_ctrl.sv
src/div_sign_unit.sv
src/div_shift_sub.sv
src/int_div_iterative.sv
verif/int_div_iterative_tb.sv

// File: Bender.yml
package:
  name: int_div_iterative

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/int_div_pkg.sv
      - src/div_ctrl.sv
      - src/div_sign_unit.sv
      - src/div_shift_sub.sv
      - src/int_div_iterative.sv
  - target: test
    files:
      - verif/int_div_iterative_tb.sv

// File: verif/int_div_iterative_tb.sv
// iterative integer divider testbench
// table cases plus seeded random cases, latency, back-pressure and busy-request checks

`timescale 1ns/1ps
`default_nettype none

module int_div_iterative_tb
  import int_div_pkg::*;
;

  // accept edge to first edge with resp_val high
  localparam int LATENCY   = 33;
  localparam int MAX_WAIT  = 40;
  localparam int MAX_STALL = 6;
  localparam int N_RANDOM  = 20;

  logic    clk;
  logic    reset;
  logic    req_val;
  logic    req_rdy;
  div_fn_e req_fn;
  word_t   req_a;
  word_t   req_b;
  logic    resp_val;
  logic    resp_rdy;
  dword_t  resp_result;

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------

  string   tab_name[$];
  div_fn_e tab_fn[$];
  word_t   tab_a[$];
  word_t   tab_b[$];
  dword_t  tab_exp[$];
  int      tab_stall[$];

  int pass_count;
  int fail_count;
  integer seed;

  int_div_iterative UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  task automatic add_case(input string name, input div_fn_e fn, input word_t a,
                          input word_t b, input dword_t expected, input int stall);
    tab_name.push_back(name);
    tab_fn.push_back(fn);
    tab_a.push_back(a);
    tab_b.push_back(b);
    tab_exp.push_back(expected);
    tab_stall.push_back(stall);
  endtask

  // reference division with the remainder above the quotient
  // signed requests divide magnitudes and then fix the signs
  // quotient negative on differing signs and remainder following the dividend
  function automatic dword_t model_div(input div_fn_e fn, input word_t a, input word_t b);
    word_t ma;
    word_t mb;
    word_t q;
    word_t r;
    if (fn == DIV_FN_UNSIGNED) begin
      q = a / b;
      r = a % b;
    end else begin
      ma = a[31] ? -a : a;
      mb = b[31] ? -b : b;
      q  = ma / mb;
      r  = ma % mb;
      if (a[31] ^ b[31]) begin
        q = -q;
      end
      if (a[31]) begin
        r = -r;
      end
    end
    return {r, q};
  endfunction

  // ----------------------------------------
  // one request through the unit
  // ----------------------------------------

  // entered right after a rising edge and left right after the consuming edge
  task automatic run_test(input string name, input div_fn_e fn, input word_t a,
                          input word_t b, input dword_t expected, input int stall);
    int     lat;
    int     errs;
    logic   resp_seen;
    errs      = 0;
    resp_seen = 1'b0;
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(negedge clk);
    // idle after the previous consume or straight out of reset
    if (!req_rdy || resp_val) begin
      $display("%s: unit was not idle when the request was presented", name);
      errs++;
    end
    // accepting edge
    @(posedge clk);
    req_val <= 1'b0;
    // scrambled inputs must not reach the captured operands
    req_a   <= ~a;
    req_b   <= ~b;
    req_fn  <= (fn == DIV_FN_SIGNED) ? DIV_FN_UNSIGNED : DIV_FN_SIGNED;
    lat = 0;
    while (!resp_seen && lat < MAX_WAIT) begin
      @(posedge clk);
      lat++;
      // stray request while busy is to be ignored
      if (lat == 3) begin
        req_val <= 1'b1;
        req_a   <= a ^ 32'h5a5a_5a5a;
      end else if (lat == 4) begin
        req_val <= 1'b0;
      end
      @(negedge clk);
      if (req_rdy) begin
        $display("%s: req_rdy high while busy, %0d cycles after accept", name, lat);
        errs++;
      end
      resp_seen = resp_val;
    end
    if (!resp_seen) begin
      $display("%s: no response within %0d cycles", name, MAX_WAIT);
      errs++;
    end else begin
      // resp_val seen after edge k+lat is first sampled at edge k+lat+1
      if (lat + 1 != LATENCY) begin
        $display("** Error: %s latency expected %0d actual %0d", name, LATENCY, lat + 1);
        errs++;
      end
      if (resp_result !== expected) begin
        $display("** Error: %s result expected %h actual %h", name, expected, resp_result);
        errs++;
      end
      // response must sit still under back-pressure
      repeat (stall) begin
        @(posedge clk);
        @(negedge clk);
        if (!resp_val || req_rdy) begin
          $display("%s: response dropped or unit ready while stalled", name);
          errs++;
        end
        if (resp_result !== expected) begin
          $display("** Error: %s held result expected %h actual %h", name, expected,
                   resp_result);
          errs++;
        end
      end
      @(posedge clk);
      resp_rdy <= 1'b1;
      // consuming edge
      @(posedge clk);
      resp_rdy <= 1'b0;
    end
    if (errs == 0) begin
      $display("PASS %s", name);
      pass_count++;
    end else begin
      $display("FAIL %s", name);
      fail_count++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    dword_t exp_r;
    word_t  ra;
    word_t  rb;
    div_fn_e rfn;
    int     rstall;
    clk        = 1'b0;
    seed       = 73;
    pass_count = 0;
    fail_count = 0;
    reset    <= 1'b1;
    req_val  <= 1'b0;
    req_fn   <= DIV_FN_UNSIGNED;
    req_a    <= '0;
    req_b    <= '0;
    resp_rdy <= 1'b0;

    // unsigned
    add_case("u_small_dividend", DIV_FN_UNSIGNED, 32'd5, 32'd7, {32'd5, 32'd0}, 0);
    add_case("u_div_by_one", DIV_FN_UNSIGNED, 32'hdead_beef, 32'd1,
             {32'h0, 32'hdead_beef}, 1);
    add_case("u_both_msb", DIV_FN_UNSIGNED, 32'hffff_ffff, 32'h8000_0000,
             {32'h7fff_ffff, 32'h1}, 2);
    add_case("u_basic", DIV_FN_UNSIGNED, 32'd100, 32'd7, {32'd2, 32'd14}, 3);
    add_case("u_by_three", DIV_FN_UNSIGNED, 32'hffff_ffff, 32'd3,
             {32'h0, 32'h5555_5555}, 0);
    // msb set but treated as unsigned
    add_case("u_msb_dividend", DIV_FN_UNSIGNED, 32'hffff_ff9c, 32'd7,
             {32'd2, 32'd613566742}, 1);
    // signed with all four sign combinations
    add_case("s_pos_pos", DIV_FN_SIGNED, 32'd100, 32'd7, {32'd2, 32'd14}, 0);
    add_case("s_neg_pos", DIV_FN_SIGNED, 32'hffff_ff9c, 32'd7,
             {32'hffff_fffe, 32'hffff_fff2}, 5);
    add_case("s_pos_neg", DIV_FN_SIGNED, 32'd100, 32'hffff_fff9,
             {32'd2, 32'hffff_fff2}, 0);
    add_case("s_neg_neg", DIV_FN_SIGNED, 32'hffff_ff9c, 32'hffff_fff9,
             {32'hffff_fffe, 32'd14}, 2);
    // most negative dividend
    add_case("s_min_by_one", DIV_FN_SIGNED, 32'h8000_0000, 32'd1,
             {32'h0, 32'h8000_0000}, 0);
    add_case("s_min_by_two", DIV_FN_SIGNED, 32'h8000_0000, 32'd2,
             {32'h0, 32'hc000_0000}, 4);
    // zero quotient with the remainder keeping the dividend sign
    add_case("s_neg_small", DIV_FN_SIGNED, 32'hffff_fffd, 32'd5,
             {32'hffff_fffd, 32'h0}, MAX_STALL);

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (resp_val || !req_rdy) begin
      $display("reset_state: unit not idle after reset");
      $display("FAIL reset_state");
      fail_count++;
    end else begin
      $display("PASS reset_state");
      pass_count++;
    end
    @(posedge clk);

    // table cases back to back
    for (int i = 0; i < tab_name.size(); i++) begin
      run_test(tab_name[i], tab_fn[i], tab_a[i], tab_b[i], tab_exp[i], tab_stall[i]);
    end

    // seeded random cases
    for (int i = 0; i < N_RANDOM; i++) begin
      rfn = ($random(seed) & 1) ? DIV_FN_SIGNED : DIV_FN_UNSIGNED;
      ra  = $random(seed);
      rb  = $random(seed);
      if (rb == '0) begin
        rb = 32'd1;
      end
      rstall = ($random(seed) & 32'h7fff_ffff) % (MAX_STALL + 1);
      exp_r  = model_div(rfn, ra, rb);
      run_test($sformatf("rand_%0d", i), rfn, ra, rb, exp_r, rstall);
    end

    // unit back in idle after the last consume
    @(negedge clk);
    if (resp_val || !req_rdy) begin
      $display("final_state: unit not idle after the last response");
      $display("FAIL final_state");
      fail_count++;
    end else begin
      $display("PASS final_state");
      pass_count++;
    end

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    int limit;
    // table is filled at time zero
    #1;
    limit = (tab_name.size() + N_RANDOM) * (40 + MAX_STALL) + 100;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/int_div_iterative.sv
// iterative integer divider, top level
// valid/ready request and response around control, sign unit and shift-subtract core

`timescale 1ns/1ps
`default_nettype none

module int_div_iterative
  import int_div_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  // request side
  input  logic    req_val,
  output logic    req_rdy,
  input  div_fn_e req_fn,
  input  word_t   req_a,
  input  word_t   req_b,

  // response side
  output logic    resp_val,
  input  logic    resp_rdy,
  output dword_t  resp_result
);

  // control to datapath
  logic load;
  logic iterate;
  // core back to control
  logic count_zero;

  // sign unit to core and back
  word_t dividend_mag;
  word_t divisor_mag;
  word_t quotient_mag;
  word_t remainder_mag;

  // ----------------------------------------
  // control
  // ----------------------------------------

  div_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .count_zero (count_zero),
    .load       (load),
    .iterate    (iterate)
  );

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // signs handled here only
  div_sign_unit u_sign (
    .clk           (clk),
    .reset         (reset),
    .load          (load),
    .req_fn        (req_fn),
    .req_a         (req_a),
    .req_b         (req_b),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .quotient_mag  (quotient_mag),
    .remainder_mag (remainder_mag),
    .resp_result   (resp_result)
  );

  // unsigned restoring divide
  div_shift_sub u_core (
    .clk           (clk),
    .reset         (reset),
    .load          (load),
    .iterate       (iterate),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .quotient_mag  (quotient_mag),
    .remainder_mag (remainder_mag),
    .count_zero    (count_zero)
  );

endmodule

`default_nettype wire

// File: src/div_shift_sub.sv
// divider shift-subtract core
// restoring division, one quotient bit per iterate cycle

`timescale 1ns/1ps
`default_nettype none

`include "int_div_settings.svh"

module div_shift_sub
  import int_div_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  // sequencing from control
  input  logic  load,
  input  logic  iterate,

  // unsigned operands from the sign unit
  input  word_t dividend_mag,
  input  word_t divisor_mag,

  // unsigned results
  output word_t quotient_mag,
  output word_t remainder_mag,

  // last step is running
  output logic  count_zero
);

  // one guard bit above the remainder and quotient halves
  localparam int unsigned RegW = 2 * `INT_DIV_XLEN + 1;

  // partial remainder over quotient
  logic [RegW-1:0] rq_reg;
  // divisor aligned to the remainder half
  logic [RegW-1:0] div_reg;

  count_t count;

  logic [RegW-1:0] rq_shift;
  logic [RegW-1:0] rq_diff;
  logic [RegW-1:0] rq_next;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------

  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - div_reg;

  // guard bit set means the subtraction went negative
  always_comb begin
    if (rq_diff[RegW-1]) begin
      // restore, quotient bit 0
      rq_next = {rq_shift[RegW-1:1], 1'b0};
    end else begin
      // keep the difference, quotient bit 1
      rq_next = {rq_diff[RegW-1:1], 1'b1};
    end
  end

  // ----------------------------------------
  // operand and remainder registers
  // ----------------------------------------

  // payload only, valid once load has been seen
  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg  <= {{(`INT_DIV_XLEN+1){1'b0}}, dividend_mag};
      div_reg <= {1'b0, divisor_mag, {`INT_DIV_XLEN{1'b0}}};
    end else if (iterate) begin
      rq_reg  <= rq_next;
    end
  end

  // ----------------------------------------
  // iteration counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= count_t'(`INT_DIV_ITERATIONS - 1);
    end else if (iterate) begin
      // wraps after the last step, control has left calc by then
      count <= count - count_t'(1);
    end
  end

  assign count_zero = (count == '0);

  // results straight out of the register halves
  assign quotient_mag  = rq_reg[`INT_DIV_XLEN-1:0];
  assign remainder_mag = rq_reg[2*`INT_DIV_XLEN-1:`INT_DIV_XLEN];

endmodule

`default_nettype wire

// File: src/div_sign_unit.sv
// divider sign unit
// operand magnitudes on the way in, sign correction and packing on the way out

`timescale 1ns/1ps
`default_nettype none

`include "int_div_settings.svh"

module div_sign_unit
  import int_div_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  // capture strobe from control
  input  logic    load,

  // raw request operands
  input  div_fn_e req_fn,
  input  word_t   req_a,
  input  word_t   req_b,

  // magnitudes into the core
  output word_t   dividend_mag,
  output word_t   divisor_mag,

  // unsigned results from the core
  input  word_t   quotient_mag,
  input  word_t   remainder_mag,

  // signed response word
  output dword_t  resp_result
);

  // operand is negative and the request is signed
  logic a_neg;
  logic b_neg;

  // latched result signs
  logic quot_neg;
  logic rem_neg;

  word_t quotient_fix;
  word_t remainder_fix;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  // unsigned requests ignore the top bit entirely
  assign a_neg = (req_fn == DIV_FN_SIGNED) && req_a[`INT_DIV_XLEN-1];
  assign b_neg = (req_fn == DIV_FN_SIGNED) && req_b[`INT_DIV_XLEN-1];

  // two's complement negate of negative operands
  // the most negative value maps onto itself, which is its correct unsigned magnitude
  assign dividend_mag = a_neg ? (~req_a + word_t'(1)) : req_a;
  assign divisor_mag  = b_neg ? (~req_b + word_t'(1)) : req_b;

  // ----------------------------------------
  // sign flags
  // ----------------------------------------

  // captured with the operands so the request inputs may change during calc
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (load) begin
      // quotient negative when operand signs differ
      quot_neg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
    end
  end

  // ----------------------------------------
  // result correction
  // ----------------------------------------

  // truncation toward zero falls out of dividing magnitudes
  assign quotient_fix  = quot_neg ? (~quotient_mag + word_t'(1)) : quotient_mag;
  assign remainder_fix = rem_neg ? (~remainder_mag + word_t'(1)) : remainder_mag;

  // remainder above quotient
  assign resp_result = {remainder_fix, quotient_fix};

endmodule

`default_nettype wire

// File: src/div_ctrl.sv
// divider control
// three-state FSM for the request/response handshake and the divide sequence

`timescale 1ns/1ps
`default_nettype none

module div_ctrl
  import int_div_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // from the shift-subtract core
  input  logic count_zero,

  // datapath sequencing
  output logic load,
  output logic iterate
);

  div_state_e state;
  div_state_e state_next;

  // request taken this cycle
  logic req_go;
  // response taken this cycle
  logic resp_go;

  // ----------------------------------------
  // handshake and datapath controls
  // ----------------------------------------

  // only idle takes a new request
  assign req_rdy  = (state == ST_IDLE);
  // result is held for as long as done lasts
  assign resp_val = (state == ST_DONE);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // operands and sign flags are captured on the accepting edge
  assign load    = req_go;
  // one shift-subtract step per calc cycle, including the last
  assign iterate = (state == ST_CALC);

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_go) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // count_zero marks the final step, so leave on that same edge
        if (count_zero) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // stall here under back-pressure
        if (resp_go) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// File: src/int_div_pkg.sv
// integer divider package
// width types, function encoding and control states

`default_nettype none

`include "int_div_settings.svh"

package int_div_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // one operand, quotient or remainder
  typedef logic [`INT_DIV_XLEN-1:0] word_t;

  // packed response, remainder in the upper half
  typedef logic [2*`INT_DIV_XLEN-1:0] dword_t;

  // iteration counter
  typedef logic [`INT_DIV_COUNT_W-1:0] count_t;

  // ----------------------------------------
  // encodings
  // ----------------------------------------

  // request function bit
  typedef enum logic {
    DIV_FN_SIGNED   = 1'b0,
    DIV_FN_UNSIGNED = 1'b1
  } div_fn_e;

  // control FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// File: src/int_div_settings.svh
// integer divider settings
// operand, counter and iteration parameters shared by package and datapath

`ifndef INT_DIV_SETTINGS_SVH
`define INT_DIV_SETTINGS_SVH

// operand width for dividend, divisor, quotient and remainder
`define INT_DIV_XLEN 32

// iteration counter width, wide enough to count all steps down to zero
`define INT_DIV_COUNT_W 5

// one quotient bit per step
// counter reloads to this minus one
`define INT_DIV_ITERATIONS 32

`endif
